/* sim.f */
rtl/lcdPkg.sv
rtl/apbRegPkg.sv
rtl/lcdApbRegs.sv
rtl/lcdScreenComposer.sv
rtl/lcdRefreshSequencer.sv
rtl/lcdBusDriver.sv
rtl/lcdTop.sv
tb/lcdTb.sv

/* Bender.yml */
package:
  name: lcd_apb

sources:
  - files:
      - rtl/lcdPkg.sv
      - rtl/apbRegPkg.sv
      - rtl/lcdApbRegs.sv
      - rtl/lcdScreenComposer.sv
      - rtl/lcdRefreshSequencer.sv
      - rtl/lcdBusDriver.sv
      - rtl/lcdTop.sv
  - target: test
    files:
      - tb/lcdTb.sv

/* tb/lcdTb.sv */
`timescale 1ns/1ps

module lcdTb import lcdPkg::*, apbRegPkg::*; ();

	localparam int clkPeriod = 8;
	localparam int enPulse = 4;
	localparam int byteGap = 10;
	localparam int clearWait = 50;
	localparam int byteCycles = 1 + enPulse + byteGap;
	localparam int frameTimeout = 40 * byteCycles + clearWait; // one frame plus slack

	logic clock;
	logic rstN;
	logic pSel;
	logic pEnable;
	logic pWrite;
	apbAddr_t pAddr;
	logic [31:0] pWdata;
	logic [31:0] pRdata;
	logic pReady;
	logic pSlverr;
	logic lcdOn;
	logic lcdBlon;
	logic lcdRw;
	logic lcdEn;
	logic lcdRs;
	wire [7:0] lcdData; // only the DUT drives it

	lcdXfer_t byteQ[$]; // every byte seen on the bus
	time fallQ[$];
	int widthQ[$]; // EN high time in cycles
	time riseTime = 0;
	lcdScreen_t building;
	lcdScreen_t lastFrame;
	int frameSeen = 0;
	int col = 0;
	int lineSel = 0; // 0 before any address command
	logic line1Full = 1'b0;

	lcdTop #(
		.enPulseCycles(enPulse),
		.byteGapCycles(byteGap),
		.clearWaitCycles(clearWait)
	) DUT (
		.clock(clock),
		.rstN(rstN),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.pRdata(pRdata),
		.pReady(pReady),
		.pSlverr(pSlverr),
		.lcdOn(lcdOn),
		.lcdBlon(lcdBlon),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdRs(lcdRs),
		.lcdData(lcdData)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clkPeriod / 2) clock = ~clock;
		end
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkCount(input int got, input int exp, input string name);
		if (got != exp) begin
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkLcdXfer(input lcdXfer_t got, input lcdXfer_t exp, input string name);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got rs %b data %h expected rs %b data %h",
				$time, name, got.rs, got.data, exp.rs, exp.data);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkScreen(input lcdScreen_t got, input lcdScreen_t exp, input string name);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s got \"%s|%s\" expected \"%s|%s\"", $time, name,
				got.line1, got.line2, exp.line1, exp.line2);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// rebuilds both lines from the address commands and the characters after them
	task automatic collectFrame(input lcdXfer_t b);
		if (!b.rs && b.data == 8'h80) begin
			lineSel = 1;
			col = 0;
		end else if (!b.rs && b.data == 8'hC0) begin
			line1Full = (lineSel == 1 && col == 16);
			lineSel = 2;
			col = 0;
		end else if (b.rs && lineSel != 0 && col < 16) begin
			if (lineSel == 1) begin
				building.line1[col] = b.data;
			end else begin
				building.line2[col] = b.data;
			end
			col++;
			if (lineSel == 2 && col == 16 && line1Full) begin
				lastFrame = building;
				frameSeen++;
			end
		end
	endtask

	always @(posedge lcdEn) begin
		riseTime = $time;
	end

	always @(negedge lcdEn) begin
		lcdXfer_t seen;
		if (rstN === 1'b1) begin
			seen.rs = lcdRs;
			seen.data = lcdData;
			seen.longWait = 1'b0; // not visible on the pins
			byteQ.push_back(seen);
			fallQ.push_back($time);
			widthQ.push_back(int'(($time - riseTime) / clkPeriod));
			collectFrame(seen);
		end
	end

	function automatic lcdLine_t textToLine(input string text);
		lcdLine_t line;
		for (int i = 0; i < 16; i++) begin
			line[i] = (i < text.len()) ? text[i] : 8'h20;
		end
		return line;
	endfunction

	function automatic string promptText(input int prompt, input int lineNo);
		case (prompt)
			1: return (lineNo == 1) ? "Select Master" : "";
			2: return (lineNo == 1) ? "Select Slave" : "";
			3: return (lineNo == 1) ? "Input Address" : "SW[0:11]";
			4: return (lineNo == 1) ? "Input data" : "SW[0:7]";
			5: return (lineNo == 1) ? "Input Number of" : "Bursts";
			6: return (lineNo == 1) ? "Save Config" : "";
			default: return (lineNo == 1) ? "Press Any Key" : "";
		endcase
	endfunction

	function automatic lcdScreen_t expectedScreen(input int state, input logic mode,
			input logic [15:0] l1Bits, input logic [15:0] l2Bits);
		lcdScreen_t s;
		int prompt;
		if (mode) begin
			s.line1 = textToLine($sformatf("A-%014b", l1Bits[13:0]));
			s.line2 = textToLine($sformatf("A-%014b", l2Bits[13:0]));
		end else begin
			prompt = (state <= 6) ? state : 0; // out of range shows the idle prompt
			s.line1 = textToLine(promptText(prompt, 1));
			s.line2 = textToLine(promptText(prompt, 2));
		end
		return s;
	endfunction

	task automatic apbAccess(input logic write, input apbAddr_t addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slverr);
		int waitCount;
		@(negedge clock);
		pSel = 1'b1; // setup cycle
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWdata = wdata;
		@(negedge clock);
		pEnable = 1'b1;
		waitCount = 0;
		@(posedge clock);
		while (pReady !== 1'b1) begin
			if (waitCount == 16) begin
				abortRun("APB slave never raised pReady");
			end
			waitCount++;
			@(posedge clock);
		end
		rdata = pRdata;
		slverr = pSlverr;
		@(negedge clock);
		pSel = 1'b0;
		pEnable = 1'b0;
	endtask

	task automatic apbWrite(input apbAddr_t addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apbAccess(1'b1, addr, data, rd, err);
		checkFlag(err, 1'b0, "pSlverr on write");
	endtask

	task automatic apbRead(input apbAddr_t addr, output logic [31:0] data);
		logic err;
		apbAccess(1'b0, addr, 32'h0, data, err);
		checkFlag(err, 1'b0, "pSlverr on read");
	endtask

	task automatic waitBytes(input int n);
		int cycles;
		cycles = 0;
		while (byteQ.size() < n) begin
			if (cycles > n * (byteCycles + clearWait)) begin
				abortRun("timeout waiting for bytes on the LCD bus");
			end
			cycles++;
			@(posedge clock);
		end
	endtask

	task automatic waitFrames(input int n);
		int target;
		int cycles;
		target = frameSeen + n;
		cycles = 0;
		while (frameSeen < target) begin
			if (cycles > n * frameTimeout) begin
				abortRun("timeout waiting for a complete LCD frame");
			end
			cycles++;
			@(posedge clock);
		end
	endtask

	// the next snapshot may predate a write, so the third frame after it is fresh
	task automatic waitFreshFrame();
		waitFrames(3);
	endtask

	task automatic powerUpTest();
		lcdChar_t initCmds [0:3];
		lcdXfer_t exp;
		logic [31:0] rd;
		initCmds[0] = 8'h38;
		initCmds[1] = 8'h0C;
		initCmds[2] = 8'h06;
		initCmds[3] = 8'h01;
		waitBytes(4);
		for (int i = 0; i < 4; i++) begin
			exp.rs = 1'b0;
			exp.data = initCmds[i];
			exp.longWait = 1'b0;
			checkLcdXfer(byteQ[i], exp, $sformatf("init byte %0d", i));
		end
		apbRead(regStatus, rd);
		checkWord(rd & 32'h1, 32'h1, "regStatus initDone");
	endtask

	task automatic defaultScreenTest();
		waitFrames(1);
		checkScreen(lastFrame, expectedScreen(0, 1'b0, 16'h0, 16'h0), "screen after reset");
		checkFlag(lcdBlon, 1'b0, "lcdBlon");
		checkFlag(lcdOn, 1'b1, "lcdOn");
		checkFlag(lcdRw, 1'b0, "lcdRw");
	endtask

	task automatic promptTest();
		for (int s = 0; s < 16; s++) begin
			apbWrite(regCtrl, 32'(s));
			waitFreshFrame();
			checkScreen(lastFrame, expectedScreen(s, 1'b0, 16'h0, 16'h0),
				$sformatf("prompt screen for state %0d", s));
		end
	endtask

	task automatic statusTest();
		logic [31:0] l1;
		logic [31:0] l2;
		apbWrite(regCtrl, 32'h10); // mode switch on
		for (int k = 0; k < 4; k++) begin
			l1 = $urandom;
			l2 = $urandom;
			apbWrite(regLine1, l1);
			apbWrite(regLine2, l2);
			waitFreshFrame();
			checkScreen(lastFrame, expectedScreen(0, 1'b1, l1[15:0], l2[15:0]), "status screen");
		end
	endtask

	task automatic registerTest();
		logic [31:0] w;
		logic [31:0] rd;
		logic [7:0] f1;
		logic err;
		w = $urandom;
		apbWrite(regCtrl, w);
		apbRead(regCtrl, rd);
		checkWord(rd, w & 32'h0000_011F, "regCtrl readback");
		w = $urandom;
		apbWrite(regLine1, w);
		apbRead(regLine1, rd);
		checkWord(rd, w & 32'h0000_FFFF, "regLine1 readback");
		apbWrite(regLine2, ~w);
		apbRead(regLine2, rd);
		checkWord(rd, ~w & 32'h0000_FFFF, "regLine2 readback");
		apbRead(regStatus, rd);
		f1 = rd[15:8];
		waitFrames(1);
		apbRead(regStatus, rd);
		checkWord({24'h0, rd[15:8]}, {24'h0, f1 + 8'd1}, "regStatus frameCount after a frame");
		apbWrite(regCtrl, 32'h0000_0103);
		checkFlag(lcdBlon, 1'b1, "lcdBlon after backlight write");
		apbAccess(1'b0, 4'h2, 32'h0, rd, err); // unmapped read
		checkFlag(err, 1'b1, "pSlverr on unmapped read");
		checkWord(rd, 32'h0, "pRdata on unmapped read");
		apbAccess(1'b1, regStatus, 32'hFFFF_FFFF, rd, err);
		checkFlag(err, 1'b1, "pSlverr on regStatus write");
		checkWord(rd, 32'h0, "pRdata on regStatus write");
		apbAccess(1'b1, 4'h6, 32'hFFFF_FFFF, rd, err);
		checkFlag(err, 1'b1, "pSlverr on unmapped write");
		apbRead(regCtrl, rd);
		checkWord(rd, 32'h0000_0103, "regCtrl after illegal writes");
	endtask

	task automatic timingTest();
		int expGap;
		for (int i = 0; i < widthQ.size(); i++) begin
			checkCount(widthQ[i], enPulse, "lcdEn pulse width");
		end
		for (int i = 1; i < fallQ.size(); i++) begin
			expGap = (!byteQ[i - 1].rs && byteQ[i - 1].data == 8'h01) ? clearWait : byteGap;
			checkCount(int'((fallQ[i] - fallQ[i - 1]) / clkPeriod), 1 + enPulse + expGap,
				"lcdEn fall interval");
		end
	endtask

	initial begin
		void'($urandom(69759)); // seeds the generator once
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWdata = '0;
		repeat (16) @(negedge clock);
		rstN = 1'b1;
		powerUpTest();
		defaultScreenTest();
		promptTest();
		statusTest();
		registerTest();
		timingTest();
		$display("Test OK");
		$finish;
	end

endmodule

/* rtl/lcdTop.sv */
`timescale 1ns/1ps

module lcdTop import lcdPkg::*, apbRegPkg::*; #(
	parameter int enPulseCycles = 12,
	parameter int byteGapCycles = 40,
	parameter int clearWaitCycles = 200
) (
	input logic clock,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input apbAddr_t pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlverr,
	output logic lcdOn, // module power
	output logic lcdBlon, // backlight
	output logic lcdRw,
	output logic lcdEn,
	output logic lcdRs,
	inout wire [7:0] lcdData
);

	lcdCfg_t cfg;
	lcdScreen_t screen;
	lcdXfer_t xfer;
	logic xferValid;
	logic xferReady;
	logic initDone;
	logic [7:0] frameCount;

	assign lcdOn = 1'b1;

	lcdApbRegs regs (
		.clock(clock),
		.rstN(rstN),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.pRdata(pRdata),
		.pReady(pReady),
		.pSlverr(pSlverr),
		.initDone(initDone),
		.frameCount(frameCount),
		.cfg(cfg),
		.lcdBlon(lcdBlon)
	);

	lcdScreenComposer composer (
		.clock(clock),
		.rstN(rstN),
		.cfg(cfg),
		.screen(screen)
	);

	lcdRefreshSequencer sequencer (
		.clock(clock),
		.rstN(rstN),
		.screen(screen),
		.xfer(xfer),
		.xferValid(xferValid),
		.xferReady(xferReady),
		.initDone(initDone),
		.frameCount(frameCount)
	);

	lcdBusDriver #(
		.enPulseCycles(enPulseCycles),
		.byteGapCycles(byteGapCycles),
		.clearWaitCycles(clearWaitCycles)
	) driver (
		.clock(clock),
		.rstN(rstN),
		.xfer(xfer),
		.xferValid(xferValid),
		.xferReady(xferReady),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdData(lcdData)
	);

endmodule

/* rtl/lcdBusDriver.sv */
`timescale 1ns/1ps

module lcdBusDriver import lcdPkg::*; #(
	parameter int enPulseCycles = 12,
	parameter int byteGapCycles = 40,
	parameter int clearWaitCycles = 200
) (
	input logic clock,
	input logic rstN,
	input lcdXfer_t xfer,
	input logic xferValid,
	output logic xferReady,
	output logic lcdRs,
	output logic lcdRw,
	output logic lcdEn,
	inout wire [7:0] lcdData
);

	localparam int gapMax = (clearWaitCycles > byteGapCycles) ? clearWaitCycles : byteGapCycles;
	localparam int cntMax = (gapMax > enPulseCycles) ? gapMax : enPulseCycles;
	localparam int cntW = $clog2(cntMax + 1);

	localparam logic [1:0] phIdle = 2'd0;
	localparam logic [1:0] phSetup = 2'd1; // rs/data valid, en low
	localparam logic [1:0] phPulse = 2'd2;
	localparam logic [1:0] phGap = 2'd3;

	logic [1:0] phase;
	logic [cntW-1:0] count;
	logic [cntW-1:0] gapLast;
	logic accept;
	lcdXfer_t held; // byte on the pins

	assign gapLast = held.longWait ? cntW'(clearWaitCycles - 1) : cntW'(byteGapCycles - 1);
	assign xferReady = (phase == phIdle) || (phase == phGap && count == gapLast);
	assign accept = xferValid && xferReady;

	assign lcdRs = held.rs;
	assign lcdRw = 1'b0; // write only, busy flag never read
	assign lcdData = lcdRw ? 'z : held.data;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			phase <= phIdle;
			count <= '0;
			lcdEn <= 1'b0;
			held <= '0;
		end else begin
			if (accept) begin
				held <= xfer;
			end
			case (phase)
				phIdle: begin
					if (accept) begin
						phase <= phSetup;
					end
				end
				phSetup: begin
					phase <= phPulse;
					count <= '0;
					lcdEn <= 1'b1;
				end
				phPulse: begin
					if (count == cntW'(enPulseCycles - 1)) begin
						phase <= phGap;
						count <= '0;
						lcdEn <= 1'b0;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					if (count == gapLast) begin
						phase <= accept ? phSetup : phIdle; // back to back when next byte waits
					end else begin
						count <= count + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* rtl/lcdRefreshSequencer.sv */
`timescale 1ns/1ps

module lcdRefreshSequencer import lcdPkg::*; (
	input logic clock,
	input logic rstN,
	input lcdScreen_t screen,
	output lcdXfer_t xfer,
	output logic xferValid,
	input logic xferReady,
	output logic initDone,
	output logic [7:0] frameCount
);

	// phase names the transfer loaded next
	localparam logic [2:0] phInit = 3'd0;
	localparam logic [2:0] phAddr1 = 3'd1;
	localparam logic [2:0] phChar1 = 3'd2;
	localparam logic [2:0] phAddr2 = 3'd3;
	localparam logic [2:0] phChar2 = 3'd4;

	logic [2:0] phase;
	logic [3:0] col; // column, or init step during phInit
	logic loadNext;
	lcdScreen_t screenCopy; // frame snapshot
	lcdChar_t initCmd;

	// slot empty or being taken by the driver this cycle
	assign loadNext = !xferValid || xferReady;

	always_comb begin
		case (col[1:0])
			2'd0: initCmd = cmdFunctionSet;
			2'd1: initCmd = cmdDisplayOn;
			2'd2: initCmd = cmdEntryMode;
			default: initCmd = cmdClear;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			phase <= phInit;
			col <= '0;
			xferValid <= 1'b0;
			initDone <= 1'b0;
			frameCount <= '0;
		end else if (loadNext) begin
			xferValid <= 1'b1;
			case (phase)
				phInit: begin
					if (col == 4'd3) begin
						phase <= phAddr1;
						col <= '0;
					end else begin
						col <= col + 4'd1;
					end
				end
				phAddr1: begin
					phase <= phChar1;
					initDone <= 1'b1; // clear was just taken
				end
				phChar1: begin
					col <= col + 4'd1; // wraps to 0 after column 15
					if (col == 4'd15) begin
						phase <= phAddr2;
					end
				end
				phAddr2: phase <= phChar2;
				phChar2: begin
					col <= col + 4'd1;
					if (col == 4'd15) begin
						phase <= phAddr1;
						frameCount <= frameCount + 8'd1; // wraps at 256
					end
				end
				default: phase <= phInit;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (loadNext) begin
			case (phase)
				phInit: xfer <= '{rs: 1'b0, data: initCmd, longWait: (initCmd == cmdClear)};
				phAddr1: begin
					xfer <= '{rs: 1'b0, data: cmdLine1Addr, longWait: 1'b0};
					screenCopy <= screen; // whole frame shows this snapshot
				end
				phChar1: xfer <= '{rs: 1'b1, data: screenCopy.line1[col], longWait: 1'b0};
				phAddr2: xfer <= '{rs: 1'b0, data: cmdLine2Addr, longWait: 1'b0};
				default: xfer <= '{rs: 1'b1, data: screenCopy.line2[col], longWait: 1'b0};
			endcase
		end
	end

endmodule

/* rtl/lcdScreenComposer.sv */
`timescale 1ns/1ps

module lcdScreenComposer import lcdPkg::*; (
	input logic clock,
	input logic rstN,
	input lcdCfg_t cfg,
	output lcdScreen_t screen
);

	localparam logic [2:0] stStatus = 3'd7; // prompts use 0..6

	logic [2:0] displayState;
	lcdScreen_t nextScreen;

	// string literal to a 16 column line, padded on the right with spaces
	function automatic lcdLine_t textLine(input logic [127:0] text);
		logic [127:0] packedText;
		lcdChar_t ch;
		lcdLine_t line;
		packedText = text;
		// literals are right justified, so slide the first char up to the top byte
		for (int i = 0; i < 16; i++) begin
			if (packedText[127:120] == 8'h00) begin
				packedText = packedText << 8;
			end
		end
		for (int i = 0; i < 16; i++) begin
			ch = packedText[127 - 8 * i -: 8];
			line[i] = (ch == 8'h00) ? chSpace : ch;
		end
		return line;
	endfunction

	// "A-" then bits 13..0, msb first
	function automatic lcdLine_t statusLine(input logic [15:0] bits);
		lcdLine_t line;
		line[0] = "A";
		line[1] = "-";
		for (int i = 0; i < 14; i++) begin
			line[i + 2] = bits[13 - i] ? chOne : chZero;
		end
		return line;
	endfunction

	function automatic lcdScreen_t promptScreen(input logic [2:0] prompt);
		lcdScreen_t s;
		case (prompt)
			3'd1: begin
				s.line1 = textLine("Select Master");
				s.line2 = textLine("");
			end
			3'd2: begin
				s.line1 = textLine("Select Slave");
				s.line2 = textLine("");
			end
			3'd3: begin
				s.line1 = textLine("Input Address");
				s.line2 = textLine("SW[0:11]");
			end
			3'd4: begin
				s.line1 = textLine("Input data");
				s.line2 = textLine("SW[0:7]");
			end
			3'd5: begin
				s.line1 = textLine("Input Number of");
				s.line2 = textLine("Bursts");
			end
			3'd6: begin
				s.line1 = textLine("Save Config");
				s.line2 = textLine("");
			end
			default: begin
				s.line1 = textLine("Press Any Key");
				s.line2 = textLine("");
			end
		endcase
		return s;
	endfunction

	always_comb begin
		if (cfg.modeSwitch) begin
			displayState = stStatus;
		end else if (cfg.configState <= 4'd6) begin
			displayState = cfg.configState[2:0];
		end else begin
			displayState = 3'd0; // out of range falls back to the idle prompt
		end
	end

	always_comb begin
		if (displayState == stStatus) begin
			nextScreen.line1 = statusLine(cfg.line1Bits);
			nextScreen.line2 = statusLine(cfg.line2Bits);
		end else begin
			nextScreen = promptScreen(displayState);
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			screen <= promptScreen(3'd0);
		end else begin
			screen <= nextScreen;
		end
	end

endmodule

/* rtl/lcdApbRegs.sv */
`timescale 1ns/1ps

module lcdApbRegs import lcdPkg::*, apbRegPkg::*; (
	input logic clock,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input apbAddr_t pAddr,
	input logic [31:0] pWdata,
	output logic [31:0] pRdata,
	output logic pReady,
	output logic pSlverr,
	input logic initDone,
	input logic [7:0] frameCount,
	output lcdCfg_t cfg,
	output logic lcdBlon
);

	logic access;
	logic mapped;
	logic illegal;
	logic wrEn;
	logic [31:0] rdWord;

	assign access = pSel & pEnable; // access phase
	assign pReady = 1'b1; // zero wait states

	// read mux, also tells whether the offset exists
	always_comb begin
		mapped = 1'b1;
		rdWord = '0;
		case (pAddr)
			regCtrl: begin
				rdWord[ctrlStateMsb:ctrlStateLsb] = cfg.configState;
				rdWord[ctrlModeBit] = cfg.modeSwitch;
				rdWord[ctrlBlonBit] = lcdBlon;
			end
			regLine1: rdWord[lineBitsMsb:0] = cfg.line1Bits;
			regLine2: rdWord[lineBitsMsb:0] = cfg.line2Bits;
			regStatus: begin
				rdWord[statInitBit] = initDone;
				rdWord[statFrameMsb:statFrameLsb] = frameCount;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign illegal = !mapped || (pWrite && pAddr == regStatus); // status is read only
	assign pSlverr = access & illegal;
	assign wrEn = access & pWrite & !illegal;
	assign pRdata = (access && !pWrite && !illegal) ? rdWord : '0;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			cfg <= '0;
			lcdBlon <= 1'b0;
		end else if (wrEn) begin
			case (pAddr)
				regCtrl: begin
					cfg.configState <= pWdata[ctrlStateMsb:ctrlStateLsb];
					cfg.modeSwitch <= pWdata[ctrlModeBit];
					lcdBlon <= pWdata[ctrlBlonBit];
				end
				regLine1: cfg.line1Bits <= pWdata[lineBitsMsb:0];
				regLine2: cfg.line2Bits <= pWdata[lineBitsMsb:0];
				default: ; // filtered out by illegal
			endcase
		end
	end

endmodule

/* rtl/apbRegPkg.sv */
package apbRegPkg;

	typedef logic [3:0] apbAddr_t;

	localparam apbAddr_t regCtrl = 4'h0;
	localparam apbAddr_t regLine1 = 4'h4;
	localparam apbAddr_t regLine2 = 4'h8;
	localparam apbAddr_t regStatus = 4'hC; // read only

	// regCtrl fields
	localparam int ctrlStateLsb = 0;
	localparam int ctrlStateMsb = 3;
	localparam int ctrlModeBit = 4;
	localparam int ctrlBlonBit = 8;

	// regLine1 / regLine2
	localparam int lineBitsMsb = 15;

	// regStatus fields
	localparam int statInitBit = 0;
	localparam int statFrameLsb = 8;
	localparam int statFrameMsb = 15;

endpackage

/* rtl/lcdPkg.sv */
package lcdPkg;

	typedef logic [7:0] lcdChar_t; // ascii code

	// element 0 is the leftmost column
	typedef lcdChar_t [0:15] lcdLine_t;

	typedef struct packed {
		lcdLine_t line1;
		lcdLine_t line2;
	} lcdScreen_t;

	typedef struct packed {
		logic [3:0] configState; // prompt select
		logic modeSwitch; // 1 shows the status screen
		logic [15:0] line1Bits;
		logic [15:0] line2Bits;
	} lcdCfg_t;

	typedef struct packed {
		logic rs; // 0 command, 1 data
		lcdChar_t data;
		logic longWait; // clear needs the long settle
	} lcdXfer_t;

	// HD44780 instruction codes
	localparam lcdChar_t cmdFunctionSet = 8'h38; // 8 bit bus, 2 lines, 5x8 font
	localparam lcdChar_t cmdDisplayOn = 8'h0C; // display on, no cursor
	localparam lcdChar_t cmdEntryMode = 8'h06; // increment, no shift
	localparam lcdChar_t cmdClear = 8'h01;
	localparam lcdChar_t cmdLine1Addr = 8'h80; // ddram 0x00
	localparam lcdChar_t cmdLine2Addr = 8'hC0; // ddram 0x40

	localparam lcdChar_t chSpace = 8'h20;
	localparam lcdChar_t chZero = 8'h30;
	localparam lcdChar_t chOne = 8'h31;

endpackage
